//--- logic/mem_pkg.sv
// widths, region map, ram geometry and device offsets of the memory stage
// funct3 load/store encodings and region classification enums
package mem_pkg;

  // data and address width
  localparam int XLEN = 64;

  // ram region, 256 MB window
  localparam logic [XLEN-1:0] MEM_BASE = 64'h0000_0000_8000_0000;
  localparam logic [XLEN-1:0] MEM_SIZE = 64'h0000_0000_1000_0000;

  // device region, 4 KB window
  localparam logic [XLEN-1:0] DEV_BASE = 64'h0000_0000_2000_0000;
  localparam logic [XLEN-1:0] DEV_SIZE = 64'h0000_0000_0000_1000;

  // backing store, indexed by addr[11:3]
  // upper ram-region addresses alias onto it
  localparam int RAM_AW    = 9;
  localparam int RAM_WORDS = 1 << RAM_AW;

  // device register map, offset inside the 4 KB window
  localparam int DEV_OFF_W = 12;
  // free-running cycle counter, read only
  localparam logic [DEV_OFF_W-1:0] DEV_MTIME_OFF   = 12'h000;
  // general purpose read/write word
  localparam logic [DEV_OFF_W-1:0] DEV_SCRATCH_OFF = 12'h008;

  // load funct3, stores only look at bits [1:0]
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_D  = 3'b011,
    F3_BU = 3'b100,
    F3_HU = 3'b101,
    F3_WU = 3'b110
  } funct3_e;

  // address decode result
  typedef enum logic [1:0] {
    REG_NONE = 2'd0,
    REG_MEM  = 2'd1,
    REG_DEV  = 2'd2
  } region_e;

endpackage

//--- logic/mem_bus_if.sv
// word-aligned access bus between the memory unit and one storage target
`timescale 1ns/100ps

interface mem_bus_if;
  import mem_pkg::*;

  // level strobe, high for the one cycle of the access
  logic            en;
  // 1 = store, 0 = load
  logic            wen;
  // byte address, low 3 bits always zero
  logic [XLEN-1:0] word_addr;
  // one bit per byte lane
  logic [7:0]      wstrb;
  // store data already moved into its lanes
  logic [XLEN-1:0] wdata;
  // raw word, combinational from the target
  logic [XLEN-1:0] rdata;

  modport master (
    output en, wen, word_addr, wstrb, wdata,
    input  rdata
  );

  modport target (
    input  en, wen, word_addr, wstrb, wdata,
    output rdata
  );

endinterface

//--- logic/mem_unit.sv
// memory stage decoder: region decode, alignment fault, lane strobes
// and load extension, driving the ram and device buses
`timescale 1ns/100ps

module mem_unit (
  input  logic                     i_ena,
  input  logic                     i_ren,
  input  logic                     i_wen,
  input  logic [mem_pkg::XLEN-1:0] i_addr,
  input  logic [mem_pkg::XLEN-1:0] i_wdata,
  input  mem_pkg::funct3_e         i_funct3,
  output logic [mem_pkg::XLEN-1:0] o_rdata,
  output logic                     o_fault,
  mem_bus_if.master                ram_bus,
  mem_bus_if.master                dev_bus
);
  import mem_pkg::*;

  logic            active;
  region_e         region;
  logic [1:0]      width;
  logic [2:0]      lane;
  logic            misaligned;
  logic [7:0]      size_mask;
  logic            go;
  logic [XLEN-1:0] raw_word;
  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] load_ext;

  // any request at all this cycle
  assign active = i_ena & (i_ren | i_wen);
  // access size, 0=B 1=H 2=W 3=D
  assign width  = i_funct3[1:0];
  // byte offset inside the doubleword
  assign lane   = i_addr[2:0];

  // region match by masking off the window offset
  always_comb begin
    if ((i_addr & ~(MEM_SIZE - 64'd1)) == MEM_BASE) begin
      region = REG_MEM;
    end else if ((i_addr & ~(DEV_SIZE - 64'd1)) == DEV_BASE) begin
      region = REG_DEV;
    end else begin
      region = REG_NONE;
    end
  end

  // alignment check and unshifted lane mask per width
  always_comb begin
    case (width)
      2'd0: begin
        misaligned = 1'b0;
        size_mask  = 8'h01;
      end
      2'd1: begin
        misaligned = lane[0];
        size_mask  = 8'h03;
      end
      2'd2: begin
        misaligned = |lane[1:0];
        size_mask  = 8'h0f;
      end
      default: begin
        misaligned = |lane;
        size_mask  = 8'hff;
      end
    endcase
  end

  // faulting access neither reads nor writes
  assign o_fault = active & ((region == REG_NONE) | misaligned);
  assign go      = active & ~o_fault;

  // ram target
  assign ram_bus.en        = go & (region == REG_MEM);
  assign ram_bus.wen       = i_wen;
  assign ram_bus.word_addr = {i_addr[XLEN-1:3], 3'b000};
  assign ram_bus.wstrb     = size_mask << lane;
  assign ram_bus.wdata     = i_wdata << {lane, 3'b000};

  // device target, same request fields
  assign dev_bus.en        = go & (region == REG_DEV);
  assign dev_bus.wen       = i_wen;
  assign dev_bus.word_addr = {i_addr[XLEN-1:3], 3'b000};
  assign dev_bus.wstrb     = size_mask << lane;
  assign dev_bus.wdata     = i_wdata << {lane, 3'b000};

  // pick the decoded target, move addressed lanes to bit 0
  assign raw_word = (region == REG_DEV) ? dev_bus.rdata : ram_bus.rdata;
  assign shifted  = raw_word >> {lane, 3'b000};

  // sign or zero extension by funct3
  always_comb begin
    case (i_funct3)
      F3_B:    load_ext = {{56{shifted[7]}}, shifted[7:0]};
      F3_H:    load_ext = {{48{shifted[15]}}, shifted[15:0]};
      F3_W:    load_ext = {{32{shifted[31]}}, shifted[31:0]};
      F3_BU:   load_ext = {56'd0, shifted[7:0]};
      F3_HU:   load_ext = {48'd0, shifted[15:0]};
      F3_WU:   load_ext = {32'd0, shifted[31:0]};
      F3_D:    load_ext = shifted;
      default: load_ext = shifted;
    endcase
  end

  // zero unless a good load
  assign o_rdata = (go & i_ren) ? load_ext : '0;

endmodule

//--- logic/mem_access.sv
// data ram of the memory stage, byte-strobed writes, combinational reads
`timescale 1ns/100ps

module mem_access (
  input  logic       clk,
  mem_bus_if.target  bus
);
  import mem_pkg::*;

  // 512 x 64 bit storage, no reset
  logic [XLEN-1:0]   ram [RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              wr_en;

  // word index from addr[11:3]
  assign idx = bus.word_addr[RAM_AW+2:3];

  // store only when this target is selected
  assign wr_en = bus.en & bus.wen;

  // raw word straight out, mem_unit does lane selection
  assign bus.rdata = ram[idx];

  // per-lane write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < 8; b++) begin
        // untouched lanes keep old bytes
        if (bus.wstrb[b]) begin
          ram[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // a selected store always carries at least one lane
  a_store_has_lane : assert property (
    @(posedge clk) wr_en |-> (bus.wstrb != 8'h00)
  ) else $error("mem_access: store with empty byte strobe");

endmodule

//--- logic/devices.sv
// device block: free-running mtime counter and one scratch register
`timescale 1ns/100ps

module devices (
  input  logic       clk,
  input  logic       i_rst_n,
  mem_bus_if.target  bus
);
  import mem_pkg::*;

  logic [XLEN-1:0]      mtime;
  logic [XLEN-1:0]      scratch;
  logic [DEV_OFF_W-1:0] offset;
  logic                 scratch_wr;

  // register select inside the 4 KB window
  assign offset = bus.word_addr[DEV_OFF_W-1:0];

  // only scratch accepts writes
  assign scratch_wr = bus.en & bus.wen & (offset == DEV_SCRATCH_OFF);

  // combinational read mux, holes read 0
  always_comb begin
    case (offset)
      DEV_MTIME_OFF:   bus.rdata = mtime;
      DEV_SCRATCH_OFF: bus.rdata = scratch;
      default:         bus.rdata = '0;
    endcase
  end

  // cycle counter, +1 every edge out of reset
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  // scratch, lane merge on strobed write
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      scratch <= '0;
    end else if (scratch_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (bus.wstrb[b]) begin
          scratch[8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  // master must hand over a doubleword-aligned address
  a_word_aligned : assert property (
    @(posedge clk) disable iff (!i_rst_n)
    bus.en |-> (bus.word_addr[2:0] == 3'b000)
  ) else $error("devices: unaligned word address on device bus");

endmodule

//--- logic/mem_top.sv
// memory stage top: unit plus ram and device targets on two buses
`timescale 1ns/100ps

module mem_top (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_ena,
  input  logic                     i_ren,
  input  logic                     i_wen,
  input  logic [mem_pkg::XLEN-1:0] i_addr,
  input  logic [2:0]               i_funct3,
  input  logic [mem_pkg::XLEN-1:0] i_wdata,
  output logic [mem_pkg::XLEN-1:0] o_rdata,
  output logic                     o_fault
);
  import mem_pkg::*;

  // one bus per target
  mem_bus_if ram_bus ();
  mem_bus_if dev_bus ();

  // decoder, master of both buses
  mem_unit u_mem_unit (
    .i_ena    (i_ena),
    .i_ren    (i_ren),
    .i_wen    (i_wen),
    .i_addr   (i_addr),
    .i_wdata  (i_wdata),
    .i_funct3 (funct3_e'(i_funct3)),
    .o_rdata  (o_rdata),
    .o_fault  (o_fault),
    .ram_bus  (ram_bus.master),
    .dev_bus  (dev_bus.master)
  );

  // data ram at 0x8000_0000
  mem_access u_mem_access (
    .clk (clk),
    .bus (ram_bus.target)
  );

  // mtime and scratch at 0x2000_0000
  devices u_devices (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .bus     (dev_bus.target)
  );

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and power-on reset source
`timescale 1ns/100ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  localparam real CLK_HALF   = 2.0;
  localparam int  CLK_PERIOD = 4;
  localparam int  RST_CYCLES = 4;

  // free-running 4 ns clock, first rise at 2 ns
  initial begin
    o_clk = 1'b0;
    forever #CLK_HALF o_clk = ~o_clk;
  end

  // release lands on a falling edge, away from the rising one
  initial begin
    o_rst_n = 1'b0;
    #(RST_CYCLES * CLK_PERIOD);
    o_rst_n = 1'b1;
  end

endmodule

//--- verif/tb_mem_top.sv
// table-driven testbench for the memory stage: byte-level reference model,
// lcg store data, watchdog and closing report
`timescale 1ns/100ps

module tb_mem_top;
  import mem_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RST_CYCLES = 4;
  // how o_rdata of an entry is judged
  localparam int CHK_LIT = 0;
  localparam int CHK_REF = 1;
  localparam int CHK_MT1 = 2;
  localparam int CHK_MT2 = 3;

  typedef struct {
    string       name;
    logic        ena;
    logic        ren;
    logic        wen;
    logic [2:0]  f3;
    logic [63:0] addr;
    logic [63:0] wdata;
    bit          rnd;
    int          mode;
    logic [63:0] exp;
    logic        flt;
  } vec_t;

  logic        clk;
  logic        rst_n;
  logic        ena;
  logic        ren;
  logic        wen;
  logic [2:0]  f3;
  logic [63:0] addr;
  logic [63:0] wdata;
  logic [63:0] rdata;
  logic        fault;

  vec_t        tbl[$];
  bit          tbl_ready;
  int          checks;
  int          errors;
  logic [31:0] lcg_state;
  logic [63:0] mtime_first;
  // mirror of ram bytes by addr[11:0], and of the scratch word
  logic [7:0]  ram_ref [4096];
  logic [7:0]  scr_ref [8];

  tb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  mem_top uut (
    .clk      (clk),
    .i_rst_n  (rst_n),
    .i_ena    (ena),
    .i_ren    (ren),
    .i_wen    (wen),
    .i_addr   (addr),
    .i_funct3 (f3),
    .i_wdata  (wdata),
    .o_rdata  (rdata),
    .o_fault  (fault)
  );

  // numerical recipes constants
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected load value, gathered byte by byte then extended
  function automatic logic [63:0] ref_load(input logic [63:0] a, input logic [2:0] fn);
    int          n;
    logic [63:0] val;
    n   = 1 << fn[1:0];
    val = '0;
    for (int i = 0; i < n; i++) begin
      if (a[63:28] == 36'h8) begin
        val[8*i +: 8] = ram_ref[a[11:0] + i];
      end else if (a[63:12] == 52'h2_0000 && a[11:3] == 9'h001) begin
        val[8*i +: 8] = scr_ref[a[2:0] + i];
      end
    end
    // funct3 bit 2 set means unsigned
    if (!fn[2] && n < 8 && val[8*n-1]) begin
      val = val | (~64'd0 << (8 * n));
    end
    return val;
  endfunction

  function automatic void ref_store(input logic [63:0] a, input logic [2:0] fn,
                                    input logic [63:0] d);
    int n;
    n = 1 << fn[1:0];
    for (int i = 0; i < n; i++) begin
      if (a[63:28] == 36'h8) begin
        ram_ref[a[11:0] + i] = d[8*i +: 8];
      end else if (a[63:12] == 52'h2_0000 && a[11:3] == 9'h001) begin
        scr_ref[a[2:0] + i] = d[8*i +: 8];
      end
    end
  endfunction

  task automatic check_value(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      $display("mismatch %s: expected %h actual %h", what, exp, act);
      errors++;
    end
  endtask

  task automatic add_entry(input string name, input logic en, input logic rd,
                           input logic wr, input logic [2:0] fn, input logic [63:0] a,
                           input logic [63:0] d, input bit rnd, input int mode,
                           input logic [63:0] exp, input logic flt);
    vec_t v;
    v = '{name, en, rd, wr, fn, a, d, rnd, mode, exp, flt};
    tbl.push_back(v);
  endtask

  task automatic add_store(input string name, input logic [2:0] fn, input logic [63:0] a,
                           input logic [63:0] d, input bit rnd, input logic flt);
    add_entry(name, 1, 0, 1, fn, a, d, rnd, CHK_LIT, 0, flt);
  endtask

  task automatic add_load(input string name, input logic [2:0] fn, input logic [63:0] a,
                          input int mode, input logic [63:0] exp, input logic flt);
    add_entry(name, 1, 1, 0, fn, a, 0, 0, mode, exp, flt);
  endtask

  task automatic build_table();
    // random doubleword, read back at every width and offset
    add_store("sd_rand", F3_D, 'h8000_0000, 0, 1, 0);
    add_load("ld_rand", F3_D, 'h8000_0000, CHK_REF, 0, 0);
    add_load("lw_rand_4", F3_W, 'h8000_0004, CHK_REF, 0, 0);
    add_load("lwu_rand_4", F3_WU, 'h8000_0004, CHK_REF, 0, 0);
    add_load("lh_rand_6", F3_H, 'h8000_0006, CHK_REF, 0, 0);
    add_load("lhu_rand_2", F3_HU, 'h8000_0002, CHK_REF, 0, 0);
    add_load("lb_rand_7", F3_B, 'h8000_0007, CHK_REF, 0, 0);
    add_load("lbu_rand_3", F3_BU, 'h8000_0003, CHK_REF, 0, 0);
    add_store("sb_rand", F3_B, 'h8000_0001, 0, 1, 0);
    add_load("ld_rand2", F3_D, 'h8000_0000, CHK_REF, 0, 0);
    // narrow stores with the sign bit set
    add_store("sd_fill2", F3_D, 'h8000_0010, 0, 0, 0);
    add_store("sb_neg", F3_B, 'h8000_0011, 64'h1122_3344_5566_7785, 0, 0);
    add_load("lb_neg", F3_B, 'h8000_0011, CHK_LIT, 64'hffff_ffff_ffff_ff85, 0);
    add_load("lbu_neg", F3_BU, 'h8000_0011, CHK_LIT, 64'h85, 0);
    add_store("sh_neg", F3_H, 'h8000_0016, 'h9abc, 0, 0);
    add_load("lh_neg", F3_H, 'h8000_0016, CHK_LIT, 64'hffff_ffff_ffff_9abc, 0);
    add_load("lhu_neg", F3_HU, 'h8000_0016, CHK_LIT, 64'h9abc, 0);
    add_store("sw_neg", F3_W, 'h8000_0010, 64'h5555_5555_dead_beef, 0, 0);
    add_load("lw_neg", F3_W, 'h8000_0010, CHK_LIT, 64'hffff_ffff_dead_beef, 0);
    add_load("ld_word2", F3_D, 'h8000_0010, CHK_LIT, 64'h9abc_0000_dead_beef, 0);
    // single lane replaced inside a doubleword
    add_store("sd_base", F3_D, 'h8000_0020, 64'h0123_4567_89ab_cdef, 0, 0);
    add_store("sb_lane5", F3_B, 'h8000_0025, 'ha5, 0, 0);
    add_load("ld_lane5", F3_D, 'h8000_0020, CHK_LIT, 64'h0123_a567_89ab_cdef, 0);
    // scratch register, then mtime and an unused offset
    add_load("scr_reset", F3_D, 'h2000_0008, CHK_LIT, 0, 0);
    add_store("scr_wr_d", F3_D, 'h2000_0008, 0, 1, 0);
    add_load("scr_rd_d", F3_D, 'h2000_0008, CHK_REF, 0, 0);
    add_store("scr_wr_h", F3_H, 'h2000_000a, 'hbeef, 0, 0);
    add_load("scr_rd_hu", F3_HU, 'h2000_000a, CHK_LIT, 64'hbeef, 0);
    add_load("scr_rd_d2", F3_D, 'h2000_0008, CHK_REF, 0, 0);
    add_load("mtime_rd1", F3_D, 'h2000_0000, CHK_MT1, 0, 0);
    add_entry("idle_gap", 0, 0, 0, F3_D, 0, 0, 0, CHK_LIT, 0, 0);
    add_load("mtime_rd2", F3_D, 'h2000_0000, CHK_MT2, 0, 0);
    add_load("dev_hole", F3_D, 'h2000_0010, CHK_LIT, 0, 0);
    // faults leave the target word alone
    add_store("sd_fault_tgt", F3_D, 'h8000_0030, 64'h1111_2222_3333_4444, 0, 0);
    add_load("ld_unmapped", F3_D, 'h4000_0000, CHK_LIT, 0, 1);
    add_store("sd_unmapped", F3_D, 'h4000_0030, '1, 0, 1);
    add_load("lh_misal", F3_H, 'h8000_0031, CHK_LIT, 0, 1);
    add_store("sw_misal", F3_W, 'h8000_0032, '1, 0, 1);
    add_store("sd_misal", F3_D, 'h8000_0034, '1, 0, 1);
    add_load("ld_fault_tgt", F3_D, 'h8000_0030, CHK_LIT, 64'h1111_2222_3333_4444, 0);
    // idle requests
    add_store("sd_idle_base", F3_D, 'h8000_0038, 64'h0f0f_0f0f_0f0f_0f0f, 0, 0);
    add_entry("sd_ena_low", 0, 0, 1, F3_D, 'h8000_0038, '1, 0, CHK_LIT, 0, 0);
    add_entry("ld_ena_low", 0, 1, 0, F3_D, 'h8000_0038, 0, 0, CHK_LIT, 0, 0);
    add_entry("noop_unmapped", 1, 0, 0, F3_D, 'h4000_0001, 0, 0, CHK_LIT, 0, 0);
    add_load("ld_idle_tgt", F3_D, 'h8000_0038, CHK_LIT, 64'h0f0f_0f0f_0f0f_0f0f, 0);
  endtask

  initial begin
    vec_t        v;
    logic [31:0] hi;
    logic [31:0] lo;
    ena       = 1'b0;
    ren       = 1'b0;
    wen       = 1'b0;
    f3        = 3'b000;
    addr      = '0;
    wdata     = '0;
    checks    = 0;
    errors    = 0;
    lcg_state = 32'h614b9571;
    scr_ref   = '{default: 8'h00};
    build_table();
    tbl_ready = 1'b1;
    // quiet outputs while held in reset
    #(CLK_PERIOD * 2);
    check_value("reset_rdata", '0, rdata);
    check_value("reset_fault", '0, fault);
    @(posedge rst_n);
    @(posedge clk);
    foreach (tbl[i]) begin
      v = tbl[i];
      #1;
      if (v.rnd) begin
        hi      = lcg_next();
        lo      = lcg_next();
        v.wdata = {hi, lo};
      end
      ena   = v.ena;
      ren   = v.ren;
      wen   = v.wen;
      f3    = v.f3;
      addr  = v.addr;
      wdata = v.wdata;
      // sample half a ns before the next edge
      #2.5;
      check_value({v.name, " fault"}, v.flt, fault);
      case (v.mode)
        CHK_REF: check_value(v.name, ref_load(v.addr, v.f3), rdata);
        CHK_MT1: mtime_first = rdata;
        CHK_MT2: begin
          checks++;
          assert (rdata > mtime_first) else begin
            $display("mismatch %s: expected above %h actual %h", v.name, mtime_first, rdata);
            errors++;
          end
        end
        default: check_value(v.name, v.exp, rdata);
      endcase
      // the store lands on the coming edge
      if (v.ena && v.wen && !v.flt) begin
        ref_store(v.addr, v.f3, v.wdata);
      end
      @(posedge clk);
    end
    #1;
    ena = 1'b0;
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // run limit from table length plus reset and margin
  initial begin
    wait (tbl_ready);
    #((tbl.size() + RST_CYCLES + 20) * CLK_PERIOD);
    $display("timeout: the test table did not finish before the watchdog limit");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- all.f
logic/mem_pkg.sv
logic/mem_bus_if.sv
logic/mem_unit.sv
logic/mem_access.sv
logic/devices.sv
logic/mem_top.sv
verif/tb_clk_gen.sv
verif/tb_mem_top.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - logic/mem_pkg.sv
  - logic/mem_bus_if.sv
  - logic/mem_unit.sv
  - logic/mem_access.sv
  - logic/devices.sv
  - logic/mem_top.sv
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_mem_top.sv
